//--- verilog/isaPkg.sv
package isaPkg;

	localparam int wordWidth = 16;
	localparam int regCount = 4;
	localparam int regIdxWidth = $clog2(regCount);

	// JAL and JRL write their return address here
	localparam logic [regIdxWidth-1:0] linkReg = 2'd2;

	// instruction field positions
	localparam int opHi = 15;
	localparam int opLo = 12;
	localparam int rsHi = 11;
	localparam int rsLo = 10;
	localparam int rtHi = 9;
	localparam int rtLo = 8;
	localparam int rdHi = 7;
	localparam int rdLo = 6;
	localparam int immHi = 7;
	localparam int immLo = 0;
	localparam int targetHi = 11;
	localparam int targetLo = 0;
	localparam int funcHi = 5;
	localparam int funcLo = 0;

	typedef enum logic [3:0] {
		BNE = 4'd0,
		BEQ = 4'd1,
		BGZ = 4'd2,
		BLZ = 4'd3,
		ADI = 4'd4,
		ORI = 4'd5,
		LHI = 4'd6,
		LWD = 4'd7,
		SWD = 4'd8,
		JMP = 4'd9,
		JAL = 4'd10,
		RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		NOT = 6'd4,
		TCP = 6'd5,
		SHL = 6'd6,
		SHR = 6'd7,
		JPR = 6'd25,
		JRL = 6'd26,
		WWD = 6'd28,
		HLT = 6'd29
	} func_e;

endpackage

//--- verilog/ctrlPkg.sv
package ctrlPkg;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		ORR = 3'd3,
		NOT = 3'd4,
		TCP = 3'd5,
		SHL = 3'd6,
		SHR = 3'd7
	} aluOp_e;

	// SEQ also covers taken branches
	typedef enum logic [1:0] {
		SEQ = 2'd0,
		JUMP = 2'd1,
		REG = 2'd2
	} pcSrc_e;

	typedef enum logic [1:0] {
		RD = 2'd0,
		RT = 2'd1,
		LINK = 2'd2
	} dest_e;

	// all zero is a no-op
	typedef struct packed {
		aluOp_e aluOp;
		pcSrc_e pcSrc;
		dest_e dest;
		logic regWrite;
		logic aluSrcImm;
		logic immZero;
		logic lhi;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic branch;
		logic link;
		logic wwd;
		logic halt;
	} ctrl_t;

endpackage

//--- verilog/alu.sv
module alu (
	input ctrlPkg::aluOp_e op,
	input logic [isaPkg::wordWidth-1:0] a,
	input logic [isaPkg::wordWidth-1:0] b,
	output logic [isaPkg::wordWidth-1:0] result
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		case (op)
			ctrlPkg::ADD: result = a + b;
			ctrlPkg::SUB: result = a - b;
			ctrlPkg::AND: result = a & b;
			ctrlPkg::ORR: result = a | b;
			ctrlPkg::NOT: result = ~a;
			// two's complement negation
			ctrlPkg::TCP: result = ~a + 1'b1;
			ctrlPkg::SHL: result = {a[wordWidth-2:0], 1'b0};
			// arithmetic shift keeps the sign bit
			ctrlPkg::SHR: result = {a[wordWidth-1], a[wordWidth-1:1]};
			default: result = a + b;
		endcase
	end

endmodule

//--- verilog/regFile.sv
module regFile (
	input logic clk,
	input logic rstN,
	input logic [isaPkg::regIdxWidth-1:0] rAddr1,
	input logic [isaPkg::regIdxWidth-1:0] rAddr2,
	output logic [isaPkg::wordWidth-1:0] rData1,
	output logic [isaPkg::wordWidth-1:0] rData2,
	input logic wEn,
	input logic [isaPkg::regIdxWidth-1:0] wAddr,
	input logic [isaPkg::wordWidth-1:0] wData
);
	import isaPkg::*;

	logic [wordWidth-1:0] regs [regCount];

	// read ports are combinational
	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wEn) begin
			regs[wAddr] <= wData;
		end
	end

endmodule

//--- verilog/controlUnit.sv
module controlUnit (
	input logic [isaPkg::wordWidth-1:0] instr,
	output ctrlPkg::ctrl_t ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	opcode_e opcode;
	func_e func;

	assign opcode = opcode_e'(instr[opHi:opLo]);
	assign func = func_e'(instr[funcHi:funcLo]);

	always_comb begin
		ctrl = '0;
		case (opcode)
			RTYPE: begin
				case (func)
					isaPkg::ADD: ctrl.aluOp = ctrlPkg::ADD;
					isaPkg::SUB: ctrl.aluOp = ctrlPkg::SUB;
					isaPkg::AND: ctrl.aluOp = ctrlPkg::AND;
					isaPkg::ORR: ctrl.aluOp = ctrlPkg::ORR;
					isaPkg::NOT: ctrl.aluOp = ctrlPkg::NOT;
					isaPkg::TCP: ctrl.aluOp = ctrlPkg::TCP;
					isaPkg::SHL: ctrl.aluOp = ctrlPkg::SHL;
					isaPkg::SHR: ctrl.aluOp = ctrlPkg::SHR;
					default: ctrl.aluOp = ctrlPkg::ADD;
				endcase
				case (func)
					isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::ORR,
					isaPkg::NOT, isaPkg::TCP, isaPkg::SHL, isaPkg::SHR: begin
						ctrl.dest = RD;
						ctrl.regWrite = 1'b1;
					end
					JPR: ctrl.pcSrc = REG;
					JRL: begin
						ctrl.pcSrc = REG;
						ctrl.dest = LINK;
						ctrl.link = 1'b1;
						ctrl.regWrite = 1'b1;
					end
					WWD: ctrl.wwd = 1'b1;
					HLT: ctrl.halt = 1'b1;
					default: ctrl = '0;
				endcase
			end
			ADI: begin
				ctrl.aluOp = ctrlPkg::ADD;
				ctrl.aluSrcImm = 1'b1;
				ctrl.dest = RT;
				ctrl.regWrite = 1'b1;
			end
			ORI: begin
				ctrl.aluOp = ctrlPkg::ORR;
				ctrl.aluSrcImm = 1'b1;
				ctrl.immZero = 1'b1;
				ctrl.dest = RT;
				ctrl.regWrite = 1'b1;
			end
			LHI: begin
				ctrl.lhi = 1'b1;
				ctrl.dest = RT;
				ctrl.regWrite = 1'b1;
			end
			// address is rs plus the sign-extended offset
			LWD: begin
				ctrl.aluOp = ctrlPkg::ADD;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.dest = RT;
				ctrl.regWrite = 1'b1;
			end
			SWD: begin
				ctrl.aluOp = ctrlPkg::ADD;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			BNE, BEQ, BGZ, BLZ: ctrl.branch = 1'b1;
			JMP: ctrl.pcSrc = JUMP;
			JAL: begin
				ctrl.pcSrc = JUMP;
				ctrl.dest = LINK;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- verilog/datapath.sv
module datapath (
	input logic clk,
	input logic rstN,
	input logic [isaPkg::wordWidth-1:0] instr,
	input ctrlPkg::ctrl_t ctrl,
	output logic [isaPkg::wordWidth-1:0] iAddr,
	output logic [isaPkg::wordWidth-1:0] dAddr,
	output logic [isaPkg::wordWidth-1:0] dWdata,
	output logic dRead,
	output logic dWrite,
	input logic [isaPkg::wordWidth-1:0] dRdata,
	output logic [isaPkg::wordWidth-1:0] outPort,
	output logic outValid,
	output logic halted
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [wordWidth-1:0] pc, pcPlus1, pcNext, branchTarget;
	logic [wordWidth-1:0] rsData, rtData, immSext, immOp, lhiValue;
	logic [wordWidth-1:0] aluB, aluResult, wbData;
	logic [regIdxWidth-1:0] wAddr;
	logic [7:0] imm;
	logic taken, running;
	opcode_e opcode;

	assign opcode = opcode_e'(instr[opHi:opLo]);
	assign imm = instr[immHi:immLo];
	assign running = !halted;

	regFile rf (
		.clk(clk),
		.rstN(rstN),
		.rAddr1(instr[rsHi:rsLo]),
		.rAddr2(instr[rtHi:rtLo]),
		.rData1(rsData),
		.rData2(rtData),
		.wEn(ctrl.regWrite && running),
		.wAddr(wAddr),
		.wData(wbData)
	);

	// immediate forms
	assign immSext = {{(wordWidth-8){imm[7]}}, imm};
	assign immOp = ctrl.immZero ? {{(wordWidth-8){1'b0}}, imm} : immSext;
	assign lhiValue = {imm, 8'b0};
	assign aluB = ctrl.aluSrcImm ? immOp : rtData;

	alu aluUnit (
		.op(ctrl.aluOp),
		.a(rsData),
		.b(aluB),
		.result(aluResult)
	);

	always_comb begin
		case (opcode)
			BNE: taken = rsData != rtData;
			BEQ: taken = rsData == rtData;
			BGZ: taken = $signed(rsData) > 0;
			BLZ: taken = rsData[wordWidth-1];
			default: taken = 1'b0;
		endcase
	end

	assign pcPlus1 = pc + 1'b1;
	assign branchTarget = pcPlus1 + immSext;

	always_comb begin
		case (ctrl.pcSrc)
			SEQ: pcNext = (ctrl.branch && taken) ? branchTarget : pcPlus1;
			JUMP: pcNext = {pcPlus1[wordWidth-1:targetHi+1], instr[targetHi:targetLo]};
			REG: pcNext = rsData;
			default: pcNext = pcPlus1;
		endcase
	end

	// writeback select
	always_comb begin
		if (ctrl.link) begin
			wbData = pcPlus1;
		end else if (ctrl.lhi) begin
			wbData = lhiValue;
		end else if (ctrl.memToReg) begin
			wbData = dRdata;
		end else begin
			wbData = aluResult;
		end
	end

	always_comb begin
		case (ctrl.dest)
			RT: wAddr = instr[rtHi:rtLo];
			LINK: wAddr = linkReg;
			default: wAddr = instr[rdHi:rdLo];
		endcase
	end

	// PC holds on HLT so it stays on the halting instruction
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (running && !ctrl.halt) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (ctrl.halt) begin
			halted <= 1'b1;
		end
	end

	assign iAddr = pc;
	assign dAddr = aluResult;
	assign dWdata = rtData;
	assign dRead = ctrl.memRead && running;
	assign dWrite = ctrl.memWrite && running;
	assign outPort = rsData;
	assign outValid = ctrl.wwd && running;

endmodule

//--- verilog/cpuTop.sv
module cpuTop (
	input logic clk,
	input logic rstN,
	output logic [isaPkg::wordWidth-1:0] iAddr,
	input logic [isaPkg::wordWidth-1:0] instr,
	output logic [isaPkg::wordWidth-1:0] dAddr,
	output logic [isaPkg::wordWidth-1:0] dWdata,
	output logic dRead,
	output logic dWrite,
	input logic [isaPkg::wordWidth-1:0] dRdata,
	output logic [isaPkg::wordWidth-1:0] outPort,
	output logic outValid,
	output logic halted
);
	import ctrlPkg::*;

	ctrl_t ctrl;

	controlUnit ctrlUnit (
		.instr(instr),
		.ctrl(ctrl)
	);

	datapath dp (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.ctrl(ctrl),
		.iAddr(iAddr),
		.dAddr(dAddr),
		.dWdata(dWdata),
		.dRead(dRead),
		.dWrite(dWrite),
		.dRdata(dRdata),
		.outPort(outPort),
		.outValid(outValid),
		.halted(halted)
	);

endmodule

//--- verif/cpuChecker.sv
module cpuChecker (
	input logic clk,
	input logic rstN,
	input logic [isaPkg::wordWidth-1:0] iAddr,
	input logic dRead,
	input logic dWrite,
	input logic outValid,
	input logic halted
);

	noReadWrite: assert property (@(posedge clk) disable iff (!rstN) !(dRead && dWrite))
		else $error("dRead and dWrite high in the same cycle");

	// halted is sticky and freezes the PC
	haltHolds: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted && $stable(iAddr))
		else $error("halted dropped or iAddr moved after halt");

	quietHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !outValid && !dWrite)
		else $error("strobe high while halted");

	quietReset: assert property (@(posedge clk) !rstN |-> !outValid && !dWrite)
		else $error("strobe high during reset");

endmodule

bind datapath cpuChecker chk (
	.clk(clk),
	.rstN(rstN),
	.iAddr(iAddr),
	.dRead(dRead),
	.dWrite(dWrite),
	.outValid(outValid),
	.halted(halted)
);

//--- verif/cpuTb.sv
module cpuTb;
	import isaPkg::*;

	localparam int cycleLimit = 200;
	localparam int numTests = 6;
	// reset, run limit and a few idle cycles per test
	localparam int watchdogTime = numTests * (cycleLimit + 12) * 4 + 100;

	logic clk, rstN, dRead, dWrite, outValid, halted;
	logic [wordWidth-1:0] iAddr, instr, dAddr, dWdata, dRdata, outPort;
	logic [wordWidth-1:0] imem [64];
	logic [wordWidth-1:0] dmem [64];
	logic [wordWidth-1:0] expMem [64];
	logic [wordWidth-1:0] expOut [$];
	logic [wordWidth-1:0] expAddr [$];
	logic [wordWidth-1:0] expData [$];
	integer seed;
	int loadAddr, testErrors, passCount, failCount;
	bit refStopped;

	cpuTop dut (
		.clk(clk),
		.rstN(rstN),
		.iAddr(iAddr),
		.instr(instr),
		.dAddr(dAddr),
		.dWdata(dWdata),
		.dRead(dRead),
		.dWrite(dWrite),
		.dRdata(dRdata),
		.outPort(outPort),
		.outValid(outValid),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [15:0] encR(func_e f, logic [1:0] rs, logic [1:0] rt,
			logic [1:0] rd);
		return {RTYPE, rs, rt, rd, f};
	endfunction

	function automatic logic [15:0] encI(opcode_e op, logic [1:0] rs, logic [1:0] rt,
			logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] encJ(opcode_e op, logic [11:0] target);
		return {op, target};
	endfunction

	// ISA model of the program in imem, starting from the current dmem
	function automatic void refRun(int maxSteps);
		logic [15:0] r [4];
		logic [15:0] pc, ir, a, b, sx, nxt, addr;
		logic [3:0] op;
		logic [5:0] fn;
		logic [1:0] rs, rt, rd;
		for (int i = 0; i < 4; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			expMem[i] = dmem[i];
		end
		expOut.delete();
		expAddr.delete();
		expData.delete();
		pc = '0;
		refStopped = 1'b0;
		for (int step = 0; step < maxSteps && !refStopped; step++) begin
			ir = imem[pc[5:0]];
			op = ir[15:12];
			fn = ir[5:0];
			rs = ir[11:10];
			rt = ir[9:8];
			rd = ir[7:6];
			a = r[rs];
			b = r[rt];
			sx = {{8{ir[7]}}, ir[7:0]};
			addr = a + sx;
			nxt = pc + 16'd1;
			case (op)
				ADI: r[rt] = a + sx;
				ORI: r[rt] = a | {8'h00, ir[7:0]};
				LHI: r[rt] = {ir[7:0], 8'h00};
				LWD: r[rt] = expMem[addr[5:0]];
				SWD: begin
					expMem[addr[5:0]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				BNE: if (a != b) nxt = nxt + sx;
				BEQ: if (a == b) nxt = nxt + sx;
				BGZ: if ($signed(a) > 0) nxt = nxt + sx;
				BLZ: if ($signed(a) < 0) nxt = nxt + sx;
				JMP: nxt = {nxt[15:12], ir[11:0]};
				JAL: begin
					r[2] = nxt;
					nxt = {nxt[15:12], ir[11:0]};
				end
				RTYPE: begin
					case (fn)
						ADD: r[rd] = a + b;
						SUB: r[rd] = a - b;
						AND: r[rd] = a & b;
						ORR: r[rd] = a | b;
						NOT: r[rd] = ~a;
						TCP: r[rd] = -a;
						SHL: r[rd] = a << 1;
						SHR: r[rd] = $signed(a) >>> 1;
						JPR: nxt = a;
						JRL: begin
							r[2] = nxt;
							nxt = a;
						end
						WWD: expOut.push_back(a);
						HLT: begin
							refStopped = 1'b1;
							nxt = pc;
						end
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = nxt;
		end
	endfunction

	task automatic put(logic [15:0] w);
		imem[loadAddr[5:0]] = w;
		loadAddr++;
	endtask

	task automatic clearMem();
		loadAddr = 0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = encR(HLT, 0, 0, 0);
			dmem[i] = 16'(i) * 16'h0103 ^ 16'h5A5A;
		end
	endtask

	// memories answer within the cycle and the store lands before the rising edge
	initial begin
		forever begin
			@(negedge clk);
			instr = imem[iAddr[5:0]];
			#1;
			if (rstN && dWrite) begin
				dmem[dAddr[5:0]] = dWdata;
			end
			if (dRead) begin
				dRdata = dmem[dAddr[5:0]];
			end
		end
	end

	// outputs depend on instr only and are stable one unit after the falling edge
	initial begin
		logic [15:0] want;
		logic wantRead;
		forever begin
			@(negedge clk);
			#1;
			// only a load reads data memory
			wantRead = instr[opHi:opLo] == LWD;
			if (rstN && dRead !== wantRead) begin
				$display("[FAIL] %0t dRead expected %b got %b", $time, wantRead, dRead);
				testErrors++;
			end
			if (rstN && outValid) begin
				if (expOut.size() == 0) begin
					$display("%0t: WWD output %h appeared when none was expected", $time, outPort);
					testErrors++;
				end else begin
					want = expOut.pop_front();
					if (outPort !== want) begin
						$display("[FAIL] %0t outPort expected %h got %h", $time, want, outPort);
						testErrors++;
					end
				end
			end
			if (rstN && dWrite) begin
				if (expAddr.size() == 0) begin
					$display("%0t: store to %h appeared when none was expected", $time, dAddr);
					testErrors++;
				end else begin
					want = expAddr.pop_front();
					if (dAddr !== want) begin
						$display("[FAIL] %0t dAddr expected %h got %h", $time, want, dAddr);
						testErrors++;
					end
					want = expData.pop_front();
					if (dWdata !== want) begin
						$display("[FAIL] %0t dWdata expected %h got %h", $time, want, dWdata);
						testErrors++;
					end
				end
			end
		end
	end

	task automatic runTest(string name);
		int cycles;
		testErrors = 0;
		refRun(cycleLimit);
		if (!refStopped) begin
			$display("%s: reference model never reached HLT", name);
			testErrors++;
		end
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		cycles = 0;
		while (!halted && cycles < cycleLimit) begin
			@(negedge clk);
			cycles++;
		end
		// instructions after HLT must stay silent
		repeat (4) @(negedge clk);
		if (!halted) begin
			$display("%s: core did not halt within %0d cycles", name, cycleLimit);
			testErrors++;
		end
		if (expOut.size() != 0) begin
			$display("%s: %0d expected WWD values never appeared", name, expOut.size());
			testErrors++;
		end
		if (expAddr.size() != 0) begin
			$display("%s: %0d expected stores never appeared", name, expAddr.size());
			testErrors++;
		end
		for (int i = 0; i < 64; i++) begin
			if (dmem[i] !== expMem[i]) begin
				$display("[FAIL] %0t dmem[%0d] expected %h got %h", $time, i, expMem[i], dmem[i]);
				testErrors++;
			end
		end
		if (testErrors == 0) begin
			passCount++;
			$display("test %s: pass", name);
		end else begin
			failCount++;
			$display("test %s: fail with %0d errors", name, testErrors);
		end
		rstN = 1'b0;
	endtask

	task automatic loadArith();
		logic [7:0] a, b, c;
		a = 8'($random(seed));
		b = 8'($random(seed));
		c = 8'($random(seed));
		put(encI(ADI, 0, 1, a));
		put(encI(ADI, 0, 2, b));
		put(encI(LHI, 0, 3, c));
		put(encR(ADD, 1, 3, 1));
		for (int f = 0; f < 8; f++) begin
			put(encR(func_e'(f), 1, 2, 3));
			put(encR(WWD, 3, 0, 0));
		end
		// fixed negative value for the shift and a wrapping add
		put(encI(LHI, 0, 3, 8'h90));
		put(encR(SHR, 3, 0, 3));
		put(encR(WWD, 3, 0, 0));
		put(encR(ADD, 3, 3, 3));
		put(encR(WWD, 3, 0, 0));
	endtask

	task automatic loadImm();
		put(encI(ADI, 0, 1, 8'hFB));
		put(encR(WWD, 1, 0, 0));
		put(encI(ADI, 1, 1, 8'h80));
		put(encR(WWD, 1, 0, 0));
		put(encI(ORI, 1, 2, 8'hF0));
		put(encR(WWD, 2, 0, 0));
		put(encI(LHI, 0, 3, 8'hA5));
		put(encR(WWD, 3, 0, 0));
		put(encI(ORI, 3, 3, 8'h5A));
		put(encR(WWD, 3, 0, 0));
	endtask

	task automatic loadMem();
		put(encI(ADI, 0, 1, 8'd10));
		put(encI(ADI, 0, 2, 8'h7C));
		put(encI(SWD, 1, 2, 8'd3));
		put(encI(SWD, 1, 1, 8'hFE));
		put(encI(LWD, 1, 3, 8'd3));
		put(encR(WWD, 3, 0, 0));
		put(encI(LWD, 1, 0, 8'hFE));
		put(encR(WWD, 0, 0, 0));
		put(encI(LWD, 1, 2, 8'd20));
		put(encR(WWD, 2, 0, 0));
	endtask

	task automatic loadBranch();
		put(encI(ADI, 0, 1, 8'd3));
		put(encI(ADI, 0, 2, 8'd1));
		put(encR(WWD, 1, 0, 0));
		put(encR(SUB, 1, 2, 1));
		put(encI(BGZ, 1, 0, 8'hFD));
		put(encI(BNE, 1, 0, 8'd1));
		put(encI(BEQ, 1, 0, 8'd1));
		put(encR(WWD, 2, 0, 0));
		put(encI(BLZ, 1, 0, 8'd1));
		put(encR(SUB, 0, 2, 3));
		put(encI(BLZ, 3, 0, 8'd1));
		put(encR(WWD, 2, 0, 0));
		put(encI(BNE, 3, 0, 8'd1));
		put(encR(WWD, 2, 0, 0));
		put(encI(BEQ, 3, 0, 8'd1));
		put(encR(WWD, 3, 0, 0));
		put(encI(BGZ, 3, 0, 8'd1));
		put(encR(WWD, 1, 0, 0));
	endtask

	task automatic loadJump();
		put(encI(ADI, 0, 1, 8'd9));
		put(encJ(JMP, 12'd4));
		put(encR(WWD, 1, 0, 0));
		put(encR(HLT, 0, 0, 0));
		put(encJ(JAL, 12'd12));
		put(encR(WWD, 2, 0, 0));
		put(encR(JPR, 1, 0, 0));
		put(encR(WWD, 1, 0, 0));
		put(encR(HLT, 0, 0, 0));
		put(encI(ADI, 0, 3, 8'd14));
		put(encR(JRL, 3, 0, 0));
		put(encR(HLT, 0, 0, 0));
		put(encR(WWD, 2, 0, 0));
		put(encR(JPR, 2, 0, 0));
		put(encR(WWD, 2, 0, 0));
		put(encR(JPR, 2, 0, 0));
	endtask

	task automatic loadHalt();
		put(encI(ADI, 0, 1, 8'd7));
		put({4'hC, 2'd1, 2'd1, 8'hFF});
		put({4'hF, 2'd1, 2'd1, 2'd1, 6'd40});
		put(encR(WWD, 1, 0, 0));
		put(encR(HLT, 0, 0, 0));
		put(encR(WWD, 1, 0, 0));
		put(encI(SWD, 0, 1, 8'd5));
		put(encI(ADI, 1, 1, 8'd1));
		put(encR(WWD, 1, 0, 0));
	endtask

	initial begin
		rstN = 1'b0;
		instr = '0;
		dRdata = '0;
		seed = 47241;
		passCount = 0;
		failCount = 0;
		testErrors = 0;
		@(negedge clk);
		clearMem();
		loadArith();
		runTest("arith");
		clearMem();
		loadImm();
		runTest("immediate");
		clearMem();
		loadMem();
		runTest("memory");
		clearMem();
		loadBranch();
		runTest("branch");
		clearMem();
		loadJump();
		runTest("jump");
		clearMem();
		loadHalt();
		runTest("halt");
		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(watchdogTime);
		$display("watchdog expired before all tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- list.f
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/cpuTop.sv
verif/cpuChecker.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpuTb -f list.f -o cpuSim
output=$(./obj_dir/cpuSim 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qF "Simulation completed successfully"
